// File: hw/sync_macros.svh
`ifndef SYNC_MACROS_SVH
`define SYNC_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// burst layout, all sizes in samples
////////////////////////////////////////////////////////////////////////////

`define FFT_POINT    16  // samples per symbol
`define CP_NUM       4   // cyclic prefix length
`define SYNC_SYM_NUM 2   // repeated sync symbols
`define DATA_SYM_NUM 4

`define SYMS_TOTAL   (`SYNC_SYM_NUM + `DATA_SYM_NUM)

// one burst with every cyclic prefix included
`define BURST_SIZE   (`SYMS_TOTAL * (`FFT_POINT + `CP_NUM))
`define IN_BUFF_SIZE (2 * `BURST_SIZE)  // input buffer holds two bursts
`define SEARCH_NUM   `BURST_SIZE        // candidate start indices

`define OUT_SIZE     (`SYMS_TOTAL * `FFT_POINT)  // symbols without prefixes

// distance between the two sync symbols
`define LAG          (`FFT_POINT + `CP_NUM)

`endif

// File: hw/sync_pkg.sv
package sync_pkg;

  // raw input sample
  typedef logic signed [7:0] sample_t;

  // correlation P, a sum of FFT_POINT sample products
  typedef logic signed [23:0] corr_t;

  // energy R, sum of squares so never negative
  typedef logic [23:0] energy_t;

  // addresses
  typedef logic [7:0] in_addr_t;   // input buffer, also candidate index
  typedef logic [6:0] out_addr_t;  // output buffer and read_ptr

endpackage

// File: hw/sample_buffer.sv
`timescale 1ns/1ps
`include "sync_macros.svh"

module sample_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               tx_done,
  input  sync_pkg::sample_t  din,
  input  logic               wren,
  output logic               buff_full,
  input  sync_pkg::in_addr_t addr_a,
  input  sync_pkg::in_addr_t addr_b,
  input  logic               copy_busy,
  input  sync_pkg::in_addr_t copy_addr,
  output sync_pkg::sample_t  rd_a,
  output sync_pkg::sample_t  rd_b
);

  sync_pkg::sample_t  mem [`IN_BUFF_SIZE];
  sync_pkg::in_addr_t wr_cnt;     // next write address
  sync_pkg::in_addr_t port_a_addr;
  logic               accept;

  assign accept = wren && !buff_full;  // drop samples once full

  // copy engine borrows port A after the sweep
  assign port_a_addr = copy_busy ? copy_addr : addr_a;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || tx_done) begin
      wr_cnt    <= '0;
      buff_full <= 1'b0;
    end else if (accept) begin
      wr_cnt <= wr_cnt + 1'b1;
      if (wr_cnt == sync_pkg::in_addr_t'(`IN_BUFF_SIZE - 1)) begin
        buff_full <= 1'b1;  // last slot taken
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[wr_cnt] <= din;
    end
  end

  // two registered read ports on the same array
  always_ff @(posedge clk) begin
    rd_a <= mem[port_a_addr];
    rd_b <= mem[addr_b];
  end

endmodule

// File: hw/timing_metric.sv
`timescale 1ns/1ps
`include "sync_macros.svh"

module timing_metric (
  input  logic               clk,
  input  logic               reset,
  input  logic               tx_done,
  input  logic               buff_full,
  output sync_pkg::in_addr_t addr_a,
  output sync_pkg::in_addr_t addr_b,
  input  sync_pkg::sample_t  rd_a,
  input  sync_pkg::sample_t  rd_b,
  output logic               cand_valid,
  output sync_pkg::in_addr_t cand_idx,
  output sync_pkg::corr_t    cand_p,
  output sync_pkg::energy_t  cand_r,
  output logic               sweep_done
);

  logic               running;  // sweep in progress
  logic               swept;    // sweep finished, wait for tx_done
  sync_pkg::in_addr_t d;        // candidate start index
  logic [4:0]         k;        // step inside one candidate
  sync_pkg::corr_t    prod_ab;
  sync_pkg::corr_t    sq_b;
  sync_pkg::corr_t    p_acc;
  sync_pkg::energy_t  r_acc;
  logic               last_cand;

  // first window at d, second one a full symbol plus prefix later
  assign addr_a = d + sync_pkg::in_addr_t'(k);
  assign addr_b = d + sync_pkg::in_addr_t'(k) + sync_pkg::in_addr_t'(`LAG);

  assign prod_ab = sync_pkg::corr_t'(rd_a) * sync_pkg::corr_t'(rd_b);
  assign sq_b    = sync_pkg::corr_t'(rd_b) * sync_pkg::corr_t'(rd_b);

  assign last_cand = (d == sync_pkg::in_addr_t'(`SEARCH_NUM - 1));

  ////////////////////////////////////////////////////////////////////////////
  // candidate sweep
  //   k = 0..FFT_POINT-1  address cycles
  //   k = FFT_POINT       last read data arrives
  //   k = FFT_POINT+1     cand_valid cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || tx_done) begin
      running    <= 1'b0;
      swept      <= 1'b0;
      d          <= '0;
      k          <= '0;
      cand_valid <= 1'b0;
      sweep_done <= 1'b0;
    end else begin
      cand_valid <= running && (k == 5'(`FFT_POINT));
      sweep_done <= cand_valid && last_cand;

      if (buff_full && !running && !swept) begin
        running <= 1'b1;
        d       <= '0;
        k       <= '0;
      end else if (running) begin
        if (k == 5'(`FFT_POINT + 1)) begin
          k <= '0;
          if (last_cand) begin
            running <= 1'b0;
            swept   <= 1'b1;
          end else begin
            d <= d + 1'b1;
          end
        end else begin
          k <= k + 1'b1;
        end
      end
    end
  end

  // read data lags the address by one, so step k carries sample k-1
  always_ff @(posedge clk) begin
    if (running && k == 5'd1) begin
      p_acc <= prod_ab;  // new candidate, restart sums
      r_acc <= sync_pkg::energy_t'(sq_b);
    end else if (running && k >= 5'd2 && k <= 5'(`FFT_POINT)) begin
      p_acc <= p_acc + prod_ab;
      r_acc <= r_acc + sync_pkg::energy_t'(sq_b);
    end
  end

  assign cand_idx = d;
  assign cand_p   = p_acc;
  assign cand_r   = r_acc;

endmodule

// File: hw/peak_detector.sv
`timescale 1ns/1ps

module peak_detector (
  input  logic               clk,
  input  logic               reset,
  input  logic               tx_done,
  input  logic               cand_valid,
  input  sync_pkg::in_addr_t cand_idx,
  input  sync_pkg::corr_t    cand_p,
  input  sync_pkg::energy_t  cand_r,
  input  logic               sweep_done,
  output logic               frame_detected,
  output sync_pkg::in_addr_t frame_start
);

  sync_pkg::energy_t  abs_p;
  sync_pkg::energy_t  best_abs_p;
  sync_pkg::energy_t  best_r;
  sync_pkg::in_addr_t best_idx;
  logic               have_best;
  logic [47:0]        lhs;
  logic [47:0]        rhs;
  logic               better;

  assign abs_p = cand_p[23] ? sync_pkg::energy_t'(-cand_p) : sync_pkg::energy_t'(cand_p);

  // |P|/R > |Pb|/Rb without a divider
  assign lhs = 48'(abs_p) * 48'(best_r);
  assign rhs = 48'(best_abs_p) * 48'(cand_r);

  // zero energy never wins, ties keep the earlier index
  assign better = (cand_r != '0) && (!have_best || lhs > rhs);

  always_ff @(posedge clk) begin
    if (reset || tx_done) begin
      have_best      <= 1'b0;
      best_idx       <= '0;  // start index when no candidate qualifies
      frame_detected <= 1'b0;
    end else begin
      if (cand_valid && better) begin
        have_best <= 1'b1;
        best_idx  <= cand_idx;
      end
      if (sweep_done) frame_detected <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cand_valid && better) begin
      best_abs_p <= abs_p;
      best_r     <= cand_r;
    end
  end

  assign frame_start = best_idx;

endmodule

// File: hw/cp_remover.sv
`timescale 1ns/1ps
`include "sync_macros.svh"

module cp_remover (
  input  logic                clk,
  input  logic                reset,
  input  logic                tx_done,
  input  logic                frame_detected,
  input  sync_pkg::in_addr_t  frame_start,
  output logic                copy_busy,
  output sync_pkg::in_addr_t  copy_addr,
  input  sync_pkg::sample_t   rd_a,
  output logic                wr_en,
  output sync_pkg::out_addr_t wr_addr,
  output sync_pkg::sample_t   wr_data,
  output logic                out_full
);

  sync_pkg::in_addr_t  src;   // source address in the input buffer
  sync_pkg::out_addr_t cnt;   // samples read so far
  logic [3:0]          seg;   // position inside the current symbol
  logic                issue;

  assign issue = copy_busy && (cnt < sync_pkg::out_addr_t'(`OUT_SIZE));

  ////////////////////////////////////////////////////////////////////////////
  // copy engine, OUT_SIZE reads then one cycle to drain the last write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || tx_done) begin
      copy_busy <= 1'b0;
      out_full  <= 1'b0;
      wr_en     <= 1'b0;
      cnt       <= '0;
      src       <= '0;
      seg       <= '0;
    end else begin
      wr_en <= issue;  // read data returns next cycle
      if (frame_detected && !copy_busy && !out_full) begin
        copy_busy <= 1'b1;
        cnt       <= '0;
        src       <= frame_start;
        seg       <= '0;
      end else if (copy_busy) begin
        if (cnt == sync_pkg::out_addr_t'(`OUT_SIZE)) begin
          copy_busy <= 1'b0;
          out_full  <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
          if (seg == 4'(`FFT_POINT - 1)) begin
            seg <= '0;
            src <= src + sync_pkg::in_addr_t'(`CP_NUM + 1);  // jump the next prefix
          end else begin
            seg <= seg + 1'b1;
            src <= src + 1'b1;
          end
        end
      end
    end
  end

  // write address follows the read by one cycle
  always_ff @(posedge clk) begin
    wr_addr <= cnt;
  end

  assign copy_addr = src;
  assign wr_data   = rd_a;

endmodule

// File: hw/out_buffer.sv
`timescale 1ns/1ps
`include "sync_macros.svh"

module out_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                tx_done,
  input  logic                wr_en,
  input  sync_pkg::out_addr_t wr_addr,
  input  sync_pkg::sample_t   wr_data,
  input  logic                out_full,
  input  sync_pkg::out_addr_t read_ptr,
  output sync_pkg::sample_t   dout
);

  sync_pkg::sample_t mem [`OUT_SIZE];
  sync_pkg::sample_t rd_q;  // ram output register

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    if (out_full) rd_q <= mem[read_ptr];
  end

  // second stage, holds while the buffer is not ready
  always_ff @(posedge clk) begin
    if (reset || tx_done) begin
      dout <= '0;
    end else if (out_full) begin
      dout <= rd_q;
    end
  end

endmodule

// File: hw/time_sync.sv
`timescale 1ns/1ps

module time_sync (
  input  logic                clk,
  input  logic                reset,
  input  sync_pkg::sample_t   din,
  input  logic                wren,
  input  logic                tx_done,
  input  sync_pkg::out_addr_t read_ptr,
  output sync_pkg::sample_t   dout,
  output logic                out_buff_full
);

  logic                buff_full;
  sync_pkg::in_addr_t  addr_a;
  sync_pkg::in_addr_t  addr_b;
  sync_pkg::sample_t   rd_a;
  sync_pkg::sample_t   rd_b;
  logic                copy_busy;
  sync_pkg::in_addr_t  copy_addr;
  logic                cand_valid;
  sync_pkg::in_addr_t  cand_idx;
  sync_pkg::corr_t     cand_p;
  sync_pkg::energy_t   cand_r;
  logic                sweep_done;
  logic                frame_detected;
  sync_pkg::in_addr_t  frame_start;
  logic                wr_en;
  sync_pkg::out_addr_t wr_addr;
  sync_pkg::sample_t   wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // input buffer and metric sweep
  ////////////////////////////////////////////////////////////////////////////

  sample_buffer sample_buffer_i (
    .clk       (clk),
    .reset     (reset),
    .tx_done   (tx_done),
    .din       (din),
    .wren      (wren),
    .buff_full (buff_full),
    .addr_a    (addr_a),
    .addr_b    (addr_b),
    .copy_busy (copy_busy),
    .copy_addr (copy_addr),
    .rd_a      (rd_a),
    .rd_b      (rd_b)
  );

  timing_metric timing_metric_i (
    .clk        (clk),
    .reset      (reset),
    .tx_done    (tx_done),
    .buff_full  (buff_full),
    .addr_a     (addr_a),
    .addr_b     (addr_b),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .cand_valid (cand_valid),
    .cand_idx   (cand_idx),
    .cand_p     (cand_p),
    .cand_r     (cand_r),
    .sweep_done (sweep_done)
  );

  peak_detector peak_detector_i (
    .clk            (clk),
    .reset          (reset),
    .tx_done        (tx_done),
    .cand_valid     (cand_valid),
    .cand_idx       (cand_idx),
    .cand_p         (cand_p),
    .cand_r         (cand_r),
    .sweep_done     (sweep_done),
    .frame_detected (frame_detected),
    .frame_start    (frame_start)
  );

  ////////////////////////////////////////////////////////////////////////////
  // prefix removal and output buffer
  ////////////////////////////////////////////////////////////////////////////

  cp_remover cp_remover_i (
    .clk            (clk),
    .reset          (reset),
    .tx_done        (tx_done),
    .frame_detected (frame_detected),
    .frame_start    (frame_start),
    .copy_busy      (copy_busy),
    .copy_addr      (copy_addr),
    .rd_a           (rd_a),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .out_full       (out_buff_full)
  );

  out_buffer out_buffer_i (
    .clk      (clk),
    .reset    (reset),
    .tx_done  (tx_done),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .out_full (out_buff_full),
    .read_ptr (read_ptr),
    .dout     (dout)
  );

endmodule

// File: dv/time_sync_tb.sv
`timescale 1ns/1ps
`include "sync_macros.svh"

module time_sync_tb;

  logic                clk;
  logic                reset;
  sync_pkg::sample_t   din;
  logic                wren;
  logic                tx_done;
  sync_pkg::out_addr_t read_ptr;
  sync_pkg::sample_t   dout;
  logic                out_buff_full;

  integer            seed;
  sync_pkg::sample_t stim [`IN_BUFF_SIZE];  // samples sent to the DUT
  sync_pkg::sample_t exp_out [`OUT_SIZE];   // expected output buffer
  int                model_start;           // frame start chosen by the model

  time_sync time_sync_i (
    .clk           (clk),
    .reset         (reset),
    .din           (din),
    .wren          (wren),
    .tx_done       (tx_done),
    .read_ptr      (read_ptr),
    .dout          (dout),
    .out_buff_full (out_buff_full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_sample(input string label, input sync_pkg::sample_t exp_v,
                              input sync_pkg::sample_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("MISMATCH dout %s expected %h actual %h", label, exp_v, act_v));
    end
  endtask

  task automatic check_flag(input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("MISMATCH out_buff_full expected %h actual %h", exp_v, act_v));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_model();
    longint p;
    longint r;
    longint ap;
    longint best_ap;
    longint best_r;
    bit     have;
    int     d;
    int     k;
    int     s;
    have        = 1'b0;
    best_ap     = 0;
    best_r      = 0;
    model_start = 0;  // kept when every candidate has zero energy
    for (d = 0; d < `SEARCH_NUM; d++) begin
      p = 0;
      r = 0;
      for (k = 0; k < `FFT_POINT; k++) begin
        p += longint'(stim[d + k]) * longint'(stim[d + k + `LAG]);
        r += longint'(stim[d + k + `LAG]) * longint'(stim[d + k + `LAG]);
      end
      ap = (p < 0) ? -p : p;
      // strictly greater by cross product, so ties stay with the earlier d
      if (r != 0 && (!have || ap * best_r > best_ap * r)) begin
        have        = 1'b1;
        best_ap     = ap;
        best_r      = r;
        model_start = d;
      end
    end
    for (s = 0; s < `SYMS_TOTAL; s++) begin
      for (k = 0; k < `FFT_POINT; k++) begin
        exp_out[s * `FFT_POINT + k] = stim[model_start + s * `LAG + k];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus builders and DUT drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_random();
    int i;
    for (i = 0; i < `IN_BUFF_SIZE; i++) begin
      stim[i] = sync_pkg::sample_t'($random(seed));
    end
  endtask

  // weak noise before off, full-scale samples from off on, sync pair at off
  task automatic plant_preamble(input int off);
    sync_pkg::sample_t sym [`FFT_POINT];
    int                i;
    int                k;
    for (i = 0; i < `IN_BUFF_SIZE; i++) begin
      if (i < off) stim[i] = ($random(seed) & 1) ? 8'sd2 : -8'sd2;
      else stim[i] = ($random(seed) & 1) ? 8'sd100 : -8'sd100;
    end
    for (k = 0; k < `FFT_POINT; k++) begin
      sym[k] = ($random(seed) & 1) ? 8'sd100 : -8'sd100;
    end
    for (i = 0; i < 2 * `LAG; i++) begin
      k = i % `LAG;
      stim[off + i] = sym[(k + `FFT_POINT - `CP_NUM) % `FFT_POINT];  // prefix then body
    end
  endtask

  task automatic send_burst();
    int i;
    for (i = 0; i < `IN_BUFF_SIZE; i++) begin
      @(posedge clk);
      #1;
      check_flag(1'b0, out_buff_full);
      wren = 1'b1;
      din  = stim[i];
    end
    @(posedge clk);
    #1;
    wren = 1'b0;
  endtask

  task automatic wait_full();
    int cycles;
    cycles = 0;
    while (!out_buff_full) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 40000) abort_run("timeout: out_buff_full never rose");
    end
  endtask

  // dout follows read_ptr by two clocks
  task automatic read_and_check();
    int i;
    for (i = 0; i < `OUT_SIZE + 2; i++) begin
      @(posedge clk);
      #1;
      check_flag(1'b1, out_buff_full);
      if (i >= 2) check_sample($sformatf("addr %0d", i - 2), exp_out[i - 2], dout);
      if (i < `OUT_SIZE) read_ptr = sync_pkg::out_addr_t'(i);
    end
  endtask

  task automatic rearm();
    @(posedge clk);
    #1;
    tx_done = 1'b1;
    @(posedge clk);
    #1;
    tx_done = 1'b0;
    check_flag(1'b0, out_buff_full);  // cleared one cycle after the pulse
    check_sample("after tx_done", 8'sd0, dout);
  endtask

  task automatic expect_start(input int off);
    if (model_start != off) begin
      abort_run($sformatf("model chose frame start %0d but the preamble sits at %0d",
                          model_start, off));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic flags_low_after_reset();
    repeat (10) begin
      @(posedge clk);
      #1;
      check_flag(1'b0, out_buff_full);
      check_sample("after reset", 8'sd0, dout);
    end
  endtask

  task automatic planted_preamble_burst();
    plant_preamble(37);
    run_model();
    expect_start(37);
    send_burst();
    wait_full();
    read_and_check();
  endtask

  task automatic extra_writes_dropped();
    rearm();
    plant_preamble(58);
    run_model();
    expect_start(58);
    send_burst();
    repeat (300) begin
      @(posedge clk);
      #1;
      wren = 1'b1;
      din  = sync_pkg::sample_t'($random(seed));  // must be dropped
    end
    @(posedge clk);
    #1;
    wren = 1'b0;
    wait_full();
    read_and_check();
  endtask

  task automatic second_burst_after_rearm();
    rearm();
    plant_preamble(91);
    run_model();
    expect_start(91);
    send_burst();
    wait_full();
    read_and_check();
  endtask

  task automatic random_burst_with_silence();
    int i;
    rearm();
    fill_random();
    // silent stretch so the leading candidates carry zero energy
    for (i = 0; i < `FFT_POINT + `CP_NUM; i++) begin
      stim[`LAG + i] = '0;
    end
    run_model();
    $display("random burst, model frame start %0d", model_start);
    send_burst();
    wait_full();
    read_and_check();
  endtask

  initial begin
    seed     = 32'hbcf1;
    reset    = 1'b1;
    din      = '0;
    wren     = 1'b0;
    tx_done  = 1'b0;
    read_ptr = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    flags_low_after_reset();
    planted_preamble_burst();
    extra_writes_dropped();
    second_burst_after_rearm();
    random_burst_with_silence();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: time_sync.f
+incdir+hw
hw/sync_pkg.sv
hw/sample_buffer.sv
hw/timing_metric.sv
hw/peak_detector.sv
hw/cp_remover.sv
hw/out_buffer.sv
hw/time_sync.sv
dv/time_sync_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module time_sync_tb \
  -f time_sync.f --Mdir obj_dir -o time_sync_sim

./obj_dir/time_sync_sim 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
